// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --timing --assert
TOP       = ice51_tb
FILELIST  = ice51.f
OBJDIR    = obj_dir
PASS_MSG  = test passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== ice51.f ====
+incdir+src
src/ice51_isa_pkg.sv
src/ice51_io_pkg.sv
src/ice51_uart_loader.sv
src/ice51_uart_tx.sv
src/ice51_decoder.sv
src/ice51_sequencer.sv
src/ice51_datapath.sv
src/ice51_top.sv
sim/ice51_sva.sv
sim/ice51_tb.sv

// ==== sim/ice51_sva.sv ====
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_sva (
   input logic       i_clk,
   input logic       i_nrst,
   input logic       i_decode0,
   input logic       i_execute,
   input logic [1:0] i_len,
   input logic       i_send,
   input logic       i_busy
);
   localparam int BUSY_CYC = 11 * (`ICE51_SAMPLE + 1);

   logic [1:0]  len_q;      // length of the instruction in flight
   logic [2:0]  since_d0;   // cycles since decode0, saturating
   logic [11:0] busy_cnt;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         len_q    <= 2'd0;
         since_d0 <= 3'd0;
         busy_cnt <= 12'd0;
      end else begin
         if (i_decode0) begin
            len_q    <= i_len;
            since_d0 <= 3'd1;
         end else if (since_d0 != 3'd7) begin
            since_d0 <= since_d0 + 3'd1;
         end
         busy_cnt <= i_busy ? busy_cnt + 12'd1 : 12'd0;
      end
   end

   ////////////////////////////////////////
   // sequencer

   // one decode cycle per instruction byte, then execute
   execute_after_len: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_execute |-> (since_d0 == {1'b0, len_q}))
      else $error("execute does not follow the instruction length");

   fetch_after_execute: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_execute |=> (!i_execute && !i_decode0))
      else $error("no fetch cycle after execute");

   ////////////////////////////////////////
   // uart transmitter

   busy_length: assert property (@(posedge i_clk) disable iff (!i_nrst)
      $fell(i_busy) |-> (busy_cnt == 12'(BUSY_CYC)))
      else $error("tx busy did not last 11 bit periods");

   no_send_when_busy: assert property (@(posedge i_clk) disable iff (!i_nrst)
      i_send |-> !i_busy)
      else $error("tx send pulse while busy");

endmodule

// ==== sim/ice51_tb.sv ====
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_tb
   import ice51_isa_pkg::*, ice51_io_pkg::*;
();
   localparam int BIT_CYC  = `ICE51_SAMPLE + 1;
   localparam int RX_FRAME = 11 * BIT_CYC;   // start, 8 data, stop, one idle bit
   localparam int TX_FRAME = 11 * BIT_CYC;
   localparam int N_OUT    = 16;
   localparam int LIMIT    = (512 * RX_FRAME + 20 * TX_FRAME) * 5 / 4;
   localparam int SEED     = 32'h6ed65f3c;

   localparam logic [15:0] STAT_ADDR = `ICE51_TX_STATUS_ADDR;
   localparam logic [15:0] DATA_ADDR = `ICE51_TX_DATA_ADDR;

   // marker bytes, one per branch path
   localparam logic [7:0] M_CY     = 8'hA5;
   localparam logic [7:0] M_NC     = 8'h5A;
   localparam logic [7:0] M_CLRC   = 8'hC3;
   localparam logic [7:0] M_NOCLR  = 8'h3C;
   localparam logic [7:0] M_NZ     = 8'h11;
   localparam logic [7:0] M_BAD_Z  = 8'h22;
   localparam logic [7:0] M_BAD_NZ = 8'h33;
   localparam logic [7:0] M_Z      = 8'h44;
   localparam logic [7:0] M_BAD_SJ = 8'h55;
   localparam logic [7:0] M_BAD_LJ = 8'h66;
   localparam logic [7:0] M_LJ     = 8'h77;

   logic       clk;
   logic       nrst;
   logic       uart_rx;
   logic       uart_tx;
   code_bus_s  code;
   logic [7:0] code_data;
   logic [7:0] image [512];
   logic [7:0] mem [512];   // external code memory
   logic [7:0] imm [12];
   logic [7:0] got [$];
   int         loc;
   int         n_wr;
   int         n_checked;
   int         cycles;

   ice51_top i_dut (.i_clk(clk), .i_nrst(nrst), .i_uart_rx(uart_rx), .o_uart_tx(uart_tx),
      .o_code(code), .i_code_data(code_data));

   bind ice51_sequencer ice51_sva u_sva_seq (.i_clk, .i_nrst, .i_decode0(o_decode0),
      .i_execute(o_execute), .i_len(i_dec.len), .i_send(1'b0), .i_busy(1'b0));
   bind ice51_uart_tx ice51_sva u_sva_tx (.i_clk, .i_nrst, .i_decode0(1'b0),
      .i_execute(1'b0), .i_len(2'd1), .i_send, .i_busy(o_busy));

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
         abort_run($sformatf("** Error: %s expected 0x%02h actual 0x%02h", name, exp, act));
   endtask

   task automatic check_write(input string name, input code_bus_s exp, input code_bus_s act);
      if (act !== exp)
         abort_run($sformatf(
            "** Error: %s expected wr=%0b addr=0x%03h data=0x%02h actual wr=%0b addr=0x%03h data=0x%02h",
            name, exp.wr, exp.addr, exp.data, act.wr, act.addr, act.data));
   endtask

   ////////////////////////////////////////
   // program image

   function automatic void emit(input logic [7:0] b);
      image[loc] = b;
      loc++;
   endfunction

   function automatic void emit2(input logic [7:0] a, input logic [7:0] b);
      emit(a);
      emit(b);
   endfunction

   function automatic logic [7:0] reg_op(input opcode_e base, input int n);
      return base | 8'(n);
   endfunction

   // offset byte is always the last one, so target is relative to slot + 1
   function automatic int branch_slot(input logic [7:0] op);
      emit2(op, 8'h00);
      return loc - 1;
   endfunction

   function automatic void patch(input int slot, input int target);
      image[slot] = 8'(target - (slot + 1));
   endfunction

   // a is kept in r6 while polling busy through r7
   function automatic void emit_send();
      int poll;
      emit(reg_op(OP_MOVRA, 6));
      poll = loc;
      emit(OP_MOVDP);
      emit2(STAT_ADDR[15:8], STAT_ADDR[7:0]);
      emit(OP_MOVXAD);
      emit(reg_op(OP_MOVRA, 7));
      emit2(reg_op(OP_CJNERI, 7), 8'h00);
      emit(8'(poll - (loc + 1)));
      emit(reg_op(OP_MOVAR, 6));
      emit(OP_MOVDP);
      emit2(DATA_ADDR[15:8], DATA_ADDR[7:0]);
      emit(OP_MOVXDA);
   endfunction

   function automatic void build_image();
      int lp;
      int s1;
      int s2;
      for (int i = 0; i < 512; i++) image[i] = 8'($urandom);
      for (int i = 0; i < 12; i++) imm[i] = 8'($urandom);
      imm[10] = imm[10] | 8'h80;   // rlc then sets carry
      imm[11] = imm[11] | 8'h01;   // never zero
      loc = `ICE51_RESET_PC;
      // accumulator arithmetic
      emit2(OP_MOVAI, imm[0]);
      emit2(OP_ADDAI, imm[1]);
      emit_send();
      emit(OP_CLRC);
      emit2(OP_SUBBAI, imm[2]);
      emit_send();
      emit2(OP_XRLAI, imm[3]);
      emit_send();
      emit(OP_DECA);
      emit_send();
      emit(OP_CLRA);
      emit_send();
      // register loop, three passes
      emit2(reg_op(OP_MOVRI, 1), imm[4]);
      lp = loc;
      emit(reg_op(OP_MOVAR, 1));
      emit_send();
      emit(reg_op(OP_INCR, 1));
      emit2(reg_op(OP_CJNERI, 1), imm[4] + 8'd3);
      emit(8'(lp - (loc + 1)));
      emit2(reg_op(OP_MOVRI, 2), imm[5]);
      emit2(OP_MOVAI, imm[6]);
      emit(reg_op(OP_ADDAR, 2));
      emit_send();
      emit2(OP_MOVAI, imm[7]);
      emit(OP_CLRC);
      emit(reg_op(OP_SUBBAR, 2));
      emit_send();
      // carry
      emit2(OP_MOVAI, imm[8]);
      emit(OP_CLRC);
      emit2(OP_SUBBAI, imm[9]);
      emit(OP_RLC);
      emit(reg_op(OP_MOVRA, 3));
      s1 = branch_slot(OP_JC);
      emit2(OP_MOVAI, M_NC);
      s2 = branch_slot(OP_SJMP);
      patch(s1, loc);
      emit2(OP_MOVAI, M_CY);
      patch(s2, loc);
      emit_send();
      emit(reg_op(OP_MOVAR, 3));
      emit_send();
      emit2(OP_MOVAI, imm[10]);
      emit(OP_RLC);
      emit(OP_CLRC);
      s1 = branch_slot(OP_JNC);
      emit2(OP_MOVAI, M_NOCLR);
      s2 = branch_slot(OP_SJMP);
      patch(s1, loc);
      emit2(OP_MOVAI, M_CLRC);
      patch(s2, loc);
      emit_send();
      // jz both ways
      emit2(OP_MOVAI, imm[11]);
      s1 = branch_slot(OP_JZ);
      emit2(OP_MOVAI, M_NZ);
      s2 = branch_slot(OP_SJMP);
      patch(s1, loc);
      emit2(OP_MOVAI, M_BAD_Z);
      patch(s2, loc);
      emit_send();
      emit(OP_CLRA);
      s1 = branch_slot(OP_JZ);
      emit2(OP_MOVAI, M_BAD_NZ);
      s2 = branch_slot(OP_SJMP);
      patch(s1, loc);
      emit2(OP_MOVAI, M_Z);
      patch(s2, loc);
      emit_send();
      // sjmp and ljmp each skip a send
      s1 = branch_slot(OP_SJMP);
      emit2(OP_MOVAI, M_BAD_SJ);
      emit_send();
      patch(s1, loc);
      emit(OP_LJMP);
      s2 = loc;
      emit2(8'h00, 8'h00);
      emit2(OP_MOVAI, M_BAD_LJ);
      emit_send();
      image[s2]     = 8'(loc >> 8);
      image[s2 + 1] = 8'(loc);
      emit2(OP_MOVAI, M_LJ);
      emit_send();
      emit2(OP_SJMP, 8'hFE);   // park here
   endfunction

   // expected k-th transmitted byte
   function automatic logic [7:0] ref_byte(input int k);
      logic [7:0] o0;
      logic [7:0] o1;
      logic [7:0] o2;
      logic [7:0] diff;
      logic       borrow;
      o0     = imm[0] + imm[1];
      o1     = o0 - imm[2];
      o2     = o1 ^ imm[3];
      diff   = imm[8] - imm[9];
      borrow = (imm[8] < imm[9]);
      case (k)
         0:       return o0;
         1:       return o1;
         2:       return o2;
         3:       return o2 - 8'd1;
         4:       return 8'h00;
         5, 6, 7: return imm[4] + 8'(k - 5);
         8:       return imm[6] + imm[5];
         9:       return imm[7] - imm[5];
         10:      return diff[7] ? M_CY : M_NC;   // rlc moved bit 7 into carry
         11:      return {diff[6:0], borrow};
         12:      return M_CLRC;
         13:      return M_NZ;
         14:      return M_Z;
         default: return M_LJ;
      endcase
   endfunction

   ////////////////////////////////////////
   // uart receive side of the dut

   task automatic send_frame(input logic [7:0] b);
      logic [9:0] bits;
      bits = {1'b1, b, 1'b0};   // lsb first after the start bit
      for (int i = 0; i < 10; i++) begin
         uart_rx = bits[i];
         repeat (BIT_CYC) @(posedge clk);
         #5;
      end
      repeat (BIT_CYC) @(posedge clk);
      #5;
   endtask

   // code memory, sampled mid cycle and answered one cycle later
   initial begin
      logic [8:0] ra;
      forever begin
         @(negedge clk);
         ra = code.addr;
         if (code.wr) begin
            if (n_wr >= 512)
               abort_run("code memory written after loading had finished");
            check_write("load", '{wr: 1'b1, addr: 9'(n_wr), data: image[n_wr]}, code);
            mem[code.addr] = code.data;
            n_wr++;
         end
         @(posedge clk);
         #5 code_data = mem[ra];
      end
   end

   // tx monitor, msb first
   initial begin
      logic [7:0] b;
      forever begin
         @(negedge clk);
         if (nrst && !uart_tx) begin
            repeat (BIT_CYC / 2) @(negedge clk);
            if (uart_tx)
               abort_run("tx start bit did not stay low");
            for (int i = 0; i < 8; i++) begin
               repeat (BIT_CYC) @(negedge clk);
               b = {b[6:0], uart_tx};
            end
            repeat (BIT_CYC) @(negedge clk);
            if (!uart_tx)
               abort_run("tx stop bit missing");
            got.push_back(b);
         end
      end
   end

   initial begin
      logic [7:0] b;
      forever begin
         @(posedge clk);
         if (got.size() != 0) begin
            b = got.pop_front();
            if (n_checked >= N_OUT)
               abort_run($sformatf("unexpected extra tx byte 0x%02h", b));
            check_byte($sformatf("tx byte %0d", n_checked), ref_byte(n_checked), b);
            n_checked++;
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > LIMIT)
         abort_run($sformatf("timeout after %0d cycles, %0d tx bytes checked",
            cycles, n_checked));
   end

   initial begin
      void'($urandom(SEED));
      nrst      = 1'b0;
      uart_rx   = 1'b1;
      code_data = 8'h00;
      n_wr      = 0;
      n_checked = 0;
      cycles    = 0;
      build_image();
      repeat (3) @(posedge clk);
      #5 nrst = 1'b1;
      for (int i = 0; i < 512; i++) send_frame(image[i]);
      while (n_checked < N_OUT) @(posedge clk);
      repeat (2 * TX_FRAME) @(posedge clk);   // room for a stray byte
      if (n_wr == 512) begin
         $display("test passed");
         $finish;
      end else begin
         abort_run($sformatf("only %0d of 512 code writes seen", n_wr));
      end
   end

endmodule

// ==== src/ice51_datapath.sv ====
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_datapath
   import ice51_isa_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_execute,
   input  dec_s       i_dec,
   input  op_u        i_op,
   input  logic [7:0] i_opnd1,
   input  logic [7:0] i_opnd2,
   input  logic       i_tx_busy,
   output logic [7:0] o_acc,
   output logic       o_branch_taken,
   output logic       o_tx_send,
   output logic [7:0] o_tx_byte
);
   logic [7:0]  bank [8];   // r0..r7
   logic [7:0]  acc;
   logic [7:0]  acc_next;
   logic        carry;
   logic        carry_next;
   logic [15:0] dptr;
   logic [7:0]  reg_sel;
   logic [7:0]  reg_next;
   logic [7:0]  operand;
   logic [8:0]  subb_res;
   logic        status_hit;
   logic        data_hit;
   logic        cond;

   assign reg_sel  = bank[i_op.g.rn];
   assign operand  = i_dec.alu_src_imm ? i_opnd1 : reg_sel;
   assign subb_res = {1'b0, acc} - {1'b0, operand} - {8'd0, carry};   // bit 8 is the borrow

   ////////////////////////////////////////
   // accumulator and carry

   always_comb begin
      case (i_dec.alu)
         ALU_PASS:   acc_next = operand;
         ALU_ADD:    acc_next = acc + operand;
         ALU_SUBB:   acc_next = subb_res[7:0];
         ALU_XRL:    acc_next = acc ^ operand;
         ALU_DEC:    acc_next = acc - 8'd1;
         ALU_CLR:    acc_next = 8'h00;
         ALU_RLC:    acc_next = {acc[6:0], carry};
         ALU_LDREG:  acc_next = reg_sel;
         ALU_LDSTAT: acc_next = {7'd0, i_dec.movx_rd & status_hit & i_tx_busy};
         default:    acc_next = acc;
      endcase
   end

   always_comb begin
      if (i_dec.carry_clr) carry_next = 1'b0;
      else if (i_dec.alu == ALU_SUBB) carry_next = subb_res[8];
      else if (i_dec.alu == ALU_RLC) carry_next = acc[7];
      else carry_next = (reg_sel < i_opnd1);   // cjne borrow
   end

   always_comb begin
      case (i_dec.reg_src)
         RSRC_IMM: reg_next = i_opnd1;
         RSRC_ACC: reg_next = acc;
         default:  reg_next = reg_sel + 8'd1;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= 8'h00;
         carry <= 1'b0;
         dptr  <= 16'h0000;
      end else if (i_execute) begin
         if (i_dec.acc_wr) acc <= acc_next;
         if (i_dec.carry_upd) carry <= carry_next;
         if (i_dec.dptr_load) dptr <= {i_opnd1, i_opnd2};   // high byte comes first
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_execute && i_dec.reg_wr) bank[i_op.g.rn] <= reg_next;
   end

   ////////////////////////////////////////
   // branch condition and i/o

   // zero test on acc happens in the sequencer
   always_comb begin
      case (i_dec.branch)
         BR_SJMP, BR_LJMP: cond = 1'b1;
         BR_JC:            cond = carry;
         BR_JNC:           cond = ~carry;
         BR_CJNE:          cond = (reg_sel != i_opnd1);
         default:          cond = 1'b0;
      endcase
   end

   assign status_hit     = (dptr == `ICE51_TX_STATUS_ADDR);
   assign data_hit       = (dptr == `ICE51_TX_DATA_ADDR);
   assign o_branch_taken = i_execute & cond;
   assign o_tx_send      = i_execute & i_dec.movx_wr & data_hit;
   assign o_tx_byte      = acc;
   assign o_acc          = acc;

endmodule

// ==== src/ice51_decoder.sv ====
`timescale 1ns/1ns

module ice51_decoder
   import ice51_isa_pkg::*;
(
   input  op_u  i_op,
   output dec_s o_dec
);
   opcode_e grp_base;
   opcode_e key;

   // register groups fold onto their rn = 0 opcode
   assign grp_base = opcode_e'({i_op.g.grp, 3'b000});

   always_comb begin
      if (grp_base inside {OP_INCR, OP_ADDAR, OP_MOVRI, OP_SUBBAR, OP_CJNERI, OP_MOVAR, OP_MOVRA})
         key = grp_base;
      else
         key = i_op.op;
   end

   always_comb begin
      case (key)
         OP_LJMP, OP_MOVDP, OP_CJNERI:                            o_dec.len = LEN_3;
         OP_ADDAI, OP_SUBBAI, OP_XRLAI, OP_MOVAI, OP_MOVRI,
         OP_SJMP, OP_JC, OP_JNC, OP_JZ:                           o_dec.len = LEN_2;
         default:                                                 o_dec.len = LEN_1;
      endcase

      case (key)
         OP_ADDAI, OP_ADDAR:   o_dec.alu = ALU_ADD;
         OP_SUBBAI, OP_SUBBAR: o_dec.alu = ALU_SUBB;
         OP_XRLAI:             o_dec.alu = ALU_XRL;
         OP_DECA:              o_dec.alu = ALU_DEC;
         OP_CLRA:              o_dec.alu = ALU_CLR;
         OP_RLC:               o_dec.alu = ALU_RLC;
         OP_MOVAR:             o_dec.alu = ALU_LDREG;
         OP_MOVXAD:            o_dec.alu = ALU_LDSTAT;
         default:              o_dec.alu = ALU_PASS;
      endcase

      case (key)
         OP_SJMP:   o_dec.branch = BR_SJMP;
         OP_LJMP:   o_dec.branch = BR_LJMP;
         OP_JC:     o_dec.branch = BR_JC;
         OP_JNC:    o_dec.branch = BR_JNC;
         OP_JZ:     o_dec.branch = BR_JZ;
         OP_CJNERI: o_dec.branch = BR_CJNE;
         default:   o_dec.branch = BR_NONE;
      endcase

      o_dec.alu_src_imm = key inside {OP_ADDAI, OP_SUBBAI, OP_XRLAI, OP_MOVAI};
      o_dec.acc_wr      = key inside {OP_ADDAI, OP_ADDAR, OP_SUBBAI, OP_SUBBAR, OP_XRLAI,
                                      OP_DECA, OP_CLRA, OP_RLC, OP_MOVAI, OP_MOVAR, OP_MOVXAD};
      o_dec.carry_upd   = key inside {OP_SUBBAI, OP_SUBBAR, OP_RLC, OP_CLRC, OP_CJNERI};
      o_dec.carry_clr   = (key == OP_CLRC);
      o_dec.reg_wr      = key inside {OP_INCR, OP_MOVRI, OP_MOVRA};
      o_dec.reg_src     = (key == OP_INCR)  ? RSRC_INC :
                          (key == OP_MOVRA) ? RSRC_ACC : RSRC_IMM;
      o_dec.dptr_load   = (key == OP_MOVDP);
      o_dec.movx_rd     = (key == OP_MOVXAD);
      o_dec.movx_wr     = (key == OP_MOVXDA);   // anything unlisted runs as a nop
   end

endmodule

// ==== src/ice51_defines.svh ====
`ifndef ICE51_DEFINES_SVH
`define ICE51_DEFINES_SVH

// clock cycles per uart bit
`define ICE51_SAMPLE          104

// code memory address width
`define ICE51_CADDR_W         9

// first opcode executed after loading
`define ICE51_RESET_PC        3

////////////////////////////////////////
// movx i/o map

`define ICE51_TX_STATUS_ADDR  16'h0200   // bit 0 reads tx busy
`define ICE51_TX_DATA_ADDR    16'h0201   // write starts a tx frame

`endif

// ==== src/ice51_io_pkg.sv ====
`include "ice51_defines.svh"

package ice51_io_pkg;

   // code memory port, loader writes and sequencer reads
   typedef struct packed {
      logic                      wr;
      logic [`ICE51_CADDR_W-1:0] addr;
      logic [7:0]                data;
   } code_bus_s;

   typedef enum logic [1:0] {
      RX_IDLE  = 2'b00,
      RX_START = 2'b01,   // wait for mid start bit
      RX_DATA  = 2'b11,
      RX_STOP  = 2'b10
   } uart_rx_state_e;

   typedef enum logic [1:0] {
      TX_IDLE  = 2'b00,
      TX_START = 2'b01,
      TX_SEND  = 2'b10
   } uart_tx_state_e;

endpackage

// ==== src/ice51_isa_pkg.sv ====
package ice51_isa_pkg;

   // kept opcodes, register groups listed with rn = 0
   typedef enum logic [7:0] {
      OP_LJMP   = 8'h02,
      OP_INCR   = 8'h08,
      OP_DECA   = 8'h14,
      OP_ADDAI  = 8'h24,
      OP_ADDAR  = 8'h28,
      OP_RLC    = 8'h33,
      OP_JC     = 8'h40,
      OP_JNC    = 8'h50,
      OP_JZ     = 8'h60,
      OP_XRLAI  = 8'h64,
      OP_MOVAI  = 8'h74,
      OP_MOVRI  = 8'h78,
      OP_SJMP   = 8'h80,
      OP_MOVDP  = 8'h90,
      OP_SUBBAI = 8'h94,
      OP_SUBBAR = 8'h98,
      OP_CJNERI = 8'hB8,
      OP_CLRC   = 8'hC3,
      OP_MOVXAD = 8'hE0,
      OP_CLRA   = 8'hE4,
      OP_MOVAR  = 8'hE8,
      OP_MOVXDA = 8'hF0,
      OP_MOVRA  = 8'hF8
   } opcode_e;

   typedef struct packed {
      logic [4:0] grp;   // upper five opcode bits
      logic [2:0] rn;    // working register index
   } op_grp_s;

   // one opcode byte seen whole or as group plus register
   typedef union packed {
      opcode_e op;
      op_grp_s g;
   } op_u;

   typedef enum logic [1:0] {LEN_1 = 2'd1, LEN_2 = 2'd2, LEN_3 = 2'd3} len_e;

   typedef enum logic [3:0] {
      ALU_PASS, ALU_ADD, ALU_SUBB, ALU_XRL, ALU_DEC,
      ALU_CLR, ALU_RLC, ALU_LDREG, ALU_LDSTAT
   } alu_e;

   typedef enum logic [2:0] {
      BR_NONE, BR_SJMP, BR_LJMP, BR_JC, BR_JNC, BR_JZ, BR_CJNE
   } branch_e;

   typedef enum logic [1:0] {RSRC_IMM, RSRC_ACC, RSRC_INC} regsrc_e;

   typedef struct packed {
      len_e    len;
      alu_e    alu;
      logic    alu_src_imm;   // operand from first byte, else rn
      logic    carry_upd;
      logic    carry_clr;
      logic    reg_wr;
      regsrc_e reg_src;
      logic    acc_wr;
      logic    dptr_load;
      logic    movx_rd;
      logic    movx_wr;
      branch_e branch;
   } dec_s;

endpackage

// ==== src/ice51_sequencer.sv ====
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_sequencer
   import ice51_isa_pkg::*;
(
   input  logic                      i_clk,
   input  logic                      i_nrst,
   input  logic                      i_load_done,
   input  logic [7:0]                i_code_data,
   input  dec_s                      i_dec,
   input  logic                      i_branch_taken,
   input  logic [7:0]                i_acc,
   output op_u                       o_op,
   output logic [7:0]                o_opnd1,
   output logic [7:0]                o_opnd2,
   output logic                      o_decode0,
   output logic                      o_execute,
   output logic [`ICE51_CADDR_W-1:0] o_code_addr
);
   localparam int           W        = `ICE51_CADDR_W;
   localparam logic [W-1:0] RESET_PC = W'(`ICE51_RESET_PC);

   typedef enum logic [2:0] {S_FETCH, S_DECODE0, S_DECODE1, S_DECODE2, S_EXECUTE} seq_state_e;

   seq_state_e state;
   seq_state_e state_next;
   op_u        op_q;
   logic [W-1:0] pc;
   logic [W-1:0] pc_next;
   logic [W-1:0] rel_tgt;
   logic [W-1:0] abs_tgt;
   logic [7:0]   rel;
   logic         taken;

   ////////////////////////////////////////
   // instruction state machine

   always_comb begin
      state_next = state;
      case (state)
         S_FETCH:   if (i_load_done) state_next = S_DECODE0;
         S_DECODE0: state_next = (i_dec.len == LEN_1) ? S_EXECUTE : S_DECODE1;
         S_DECODE1: state_next = (i_dec.len == LEN_3) ? S_DECODE2 : S_EXECUTE;
         S_DECODE2: state_next = S_EXECUTE;
         default:   state_next = S_FETCH;
      endcase
   end

   assign o_op      = (state == S_DECODE0) ? op_u'(i_code_data) : op_q;   // opcode byte arrives
   assign o_decode0 = (state == S_DECODE0);
   assign o_execute = (state == S_EXECUTE);

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= S_FETCH;
         op_q    <= '0;
         o_opnd1 <= 8'h00;
         o_opnd2 <= 8'h00;
         pc      <= RESET_PC;
      end else begin
         state <= state_next;
         pc    <= pc_next;
         if (state == S_DECODE0) op_q <= o_op;
         if (state == S_DECODE1) o_opnd1 <= i_code_data;   // second byte
         if (state == S_DECODE2) o_opnd2 <= i_code_data;   // third byte
      end
   end

   ////////////////////////////////////////
   // program counter

   // offset is always the last instruction byte
   assign rel     = (i_dec.len == LEN_3) ? o_opnd2 : o_opnd1;
   assign rel_tgt = pc + {{(W-8){rel[7]}}, rel};   // pc already past the instruction
   assign abs_tgt = W'({o_opnd1, o_opnd2});

   // jz looks at the accumulator here
   assign taken = i_branch_taken | (o_execute & (i_dec.branch == BR_JZ) & (i_acc == 8'h00));

   always_comb begin
      pc_next = pc;
      case (state)
         S_FETCH:   if (i_load_done) pc_next = pc + 1'b1;
         S_DECODE0: if (i_dec.len != LEN_1) pc_next = pc + 1'b1;
         S_DECODE1: if (i_dec.len == LEN_3) pc_next = pc + 1'b1;
         S_EXECUTE: if (taken) pc_next = (i_dec.branch == BR_LJMP) ? abs_tgt : rel_tgt;
         default:   pc_next = pc;
      endcase
   end

   assign o_code_addr = pc;   // next byte to read

endmodule

// ==== src/ice51_top.sv ====
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_top
   import ice51_isa_pkg::*, ice51_io_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_uart_rx,
   output logic       o_uart_tx,
   output code_bus_s  o_code,
   input  logic [7:0] i_code_data
);
   code_bus_s                 ld_code;
   code_bus_s                 seq_code;
   logic                      load_done;
   logic                      seq_run;
   op_u                       op;
   dec_s                      dec;
   logic [7:0]                opnd1;
   logic [7:0]                opnd2;
   logic                      execute;
   logic [`ICE51_CADDR_W-1:0] code_addr;
   logic                      branch_taken;
   logic [7:0]                acc;
   logic                      tx_send;
   logic [7:0]                tx_byte;
   logic                      tx_busy;

   ////////////////////////////////////////
   // code bus ownership

   // last loader write still owns the bus
   assign seq_run  = load_done & ~ld_code.wr;
   assign seq_code = '{wr: 1'b0, addr: code_addr, data: 8'h00};
   assign o_code   = seq_run ? seq_code : ld_code;

   ice51_uart_loader u_loader (.i_clk, .i_nrst, .i_uart_rx,
      .o_code(ld_code), .o_load_done(load_done));

   ice51_decoder u_dec (.i_op(op), .o_dec(dec));

   ice51_sequencer u_seq (.i_clk, .i_nrst, .i_load_done(seq_run), .i_code_data,
      .i_dec(dec), .i_branch_taken(branch_taken), .i_acc(acc), .o_op(op),
      .o_opnd1(opnd1), .o_opnd2(opnd2), .o_decode0(), .o_execute(execute),
      .o_code_addr(code_addr));

   ice51_datapath u_dp (.i_clk, .i_nrst, .i_execute(execute), .i_dec(dec), .i_op(op),
      .i_opnd1(opnd1), .i_opnd2(opnd2), .i_tx_busy(tx_busy), .o_acc(acc),
      .o_branch_taken(branch_taken), .o_tx_send(tx_send), .o_tx_byte(tx_byte));

   ice51_uart_tx u_tx (.i_clk, .i_nrst, .i_send(tx_send), .i_byte(tx_byte),
      .o_busy(tx_busy), .o_uart_tx);

endmodule

// ==== src/ice51_uart_loader.sv ====
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_uart_loader
   import ice51_io_pkg::*;
(
   input  logic      i_clk,
   input  logic      i_nrst,
   input  logic      i_uart_rx,
   output code_bus_s o_code,
   output logic      o_load_done
);
   localparam int               CNT_W = $clog2(`ICE51_SAMPLE + 1);
   localparam logic [CNT_W-1:0] FULL  = CNT_W'(`ICE51_SAMPLE);
   localparam logic [CNT_W-1:0] HALF  = CNT_W'(`ICE51_SAMPLE / 2);

   uart_rx_state_e            state;
   uart_rx_state_e            state_next;
   logic                      rx_q;
   logic [CNT_W-1:0]          cnt;
   logic                      cnt_clr;
   logic                      full;
   logic                      half;
   logic                      done;
   logic                      done_q;
   logic [7:0]                shreg;
   logic [`ICE51_CADDR_W-1:0] wr_addr;

   assign full    = (cnt == FULL);
   assign half    = (cnt == HALF);
   assign done    = (state == RX_STOP) & full;   // stop bit sample
   assign cnt_clr = (state == RX_IDLE) | ((state == RX_START) & half) |
                    (((state == RX_DATA) | (state == RX_STOP)) & full);

   always_comb begin
      state_next = state;
      case (state)
         RX_IDLE:  if (!rx_q) state_next = RX_START;
         RX_START: if (half) state_next = RX_DATA;
         RX_DATA:  if (full && shreg[0]) state_next = RX_STOP;   // marker reached bit 0
         default:  if (full) state_next = RX_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_q    <= 1'b1;
         state   <= RX_IDLE;
         cnt     <= '0;
         wr_addr <= '0;
         done_q  <= 1'b0;
      end else begin
         rx_q    <= i_uart_rx;
         state   <= state_next;
         cnt     <= cnt_clr ? '0 : cnt + 1'b1;
         wr_addr <= wr_addr + {{(`ICE51_CADDR_W-1){1'b0}}, done};
         done_q  <= o_load_done;
      end
   end

   // lsb first, marker bit rides ahead of the data
   always_ff @(posedge i_clk) begin
      if (state == RX_IDLE && !rx_q) shreg <= 8'h80;
      else if (state == RX_DATA && full) shreg <= {rx_q, shreg[7:1]};
   end

   assign o_load_done = done_q | (done & (wr_addr == '1));   // wrap after 512 frames
   assign o_code.wr   = done & ~done_q;
   assign o_code.addr = wr_addr;
   assign o_code.data = shreg;

endmodule

// ==== src/ice51_uart_tx.sv ====
`timescale 1ns/1ns
`include "ice51_defines.svh"

module ice51_uart_tx
   import ice51_io_pkg::*;
(
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_send,
   input  logic [7:0] i_byte,
   output logic       o_busy,
   output logic       o_uart_tx
);
   localparam int               CNT_W = $clog2(`ICE51_SAMPLE + 1);
   localparam logic [CNT_W-1:0] FULL  = CNT_W'(`ICE51_SAMPLE);

   uart_tx_state_e   state;
   uart_tx_state_e   state_next;
   logic [CNT_W-1:0] cnt;
   logic [3:0]       bit_cnt;
   logic [7:0]       shreg;
   logic             tick;
   logic             finish;
   logic             load;

   assign tick   = (cnt == FULL);
   assign finish = tick & (bit_cnt == 4'd10);   // start, 8 data, 2 stop periods
   assign load   = (state == TX_IDLE) & i_send;   // busy sends dropped

   always_comb begin
      state_next = state;
      case (state)
         TX_IDLE:  if (load) state_next = TX_START;
         TX_START: if (tick) state_next = TX_SEND;
         default:  if (finish) state_next = TX_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         state   <= state_next;
         cnt     <= (state == TX_IDLE || tick) ? '0 : cnt + 1'b1;
         bit_cnt <= finish ? 4'd0 : bit_cnt + {3'd0, tick};
      end
   end

   // msb first, ones shifted in form the stop level
   always_ff @(posedge i_clk) begin
      if (load) shreg <= i_byte;
      else if (state == TX_SEND && tick) shreg <= {shreg[6:0], 1'b1};
   end

   assign o_busy    = (state != TX_IDLE);
   assign o_uart_tx = (state == TX_IDLE) | ((state == TX_SEND) & shreg[7]);

endmodule
